// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and decide pass or fail from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tx_bit_intf -f tx_bit_intf.f -o sim_tx_bit_intf

./obj_dir/sim_tx_bit_intf +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Test passed" sim.log; then
    exit 0
fi
exit 1

// ==== tb_tx_bit_intf.sv ====
// testbench top: clock, reset, random descriptors and stream, buffer readback and verdict
`timescale 1ns/10ps

module tb_tx_bit_intf;
    import tx_bit_pkg::*;

    localparam int n_frames = 16;

    logic                   clk;
    logic                   rstn;
    logic                   dma_done;
    logic [queue_idx_w-1:0] queue_sel;
    tx_desc_t               desc_in;
    logic [num_queues-1:0]  tx_allowed;
    logic                   bb_busy;
    logic                   tx_end;
    logic                   tx_done;
    logic                   auto_start;
    logic [buf_addr_w-1:0]  start_threshold;
    logic [data_w-1:0]      data_in;
    logic                   data_valid;
    logic                   data_req;
    logic [buf_addr_w-1:0]  bram_addr;
    logic [data_w-1:0]      bram_rd_data;
    logic                   start;
    logic [queue_idx_w-1:0] tx_queue_idx;
    logic                   need_ack;
    logic [3:0]             retry_limit;
    logic [9:0]             seq_num;
    logic [1:0]             prio;
    logic                   rd_check;
    logic                   report;
    int                     timeouts = 0;
    int                     chk_errs;
    int                     assert_errs;
    integer                 seed = 39;

    tx_bit_intf i_dut (.*);

    tx_bit_intf_checker i_checker (.*, .errs(chk_errs));

    bind tx_queue_arbiter tx_bit_intf_assertions i_arb_assert (
        .clk     (clk),
        .rstn    (rstn),
        .pop     (pop),
        .load_go (load_go),
        .bb_busy (bb_busy),
        .state   (state)
    );

    assign assert_errs = i_dut.i_arbiter.i_arb_assert.fail_cnt;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // stream source, data_valid gaps at random
    initial begin
        data_valid = 1'b0;
        data_in    = '0;
        forever begin
            @(posedge clk);
            data_valid <= rstn && (($random(seed) % 2) != 0);
            data_in    <= {$random(seed), $random(seed)};
        end
    end

    // one dma completion on a random queue
    task automatic write_desc();
        tx_desc_t d;
        d           = tx_desc_t'($random(seed));
        d.len_words = 13'(1 + $unsigned($random(seed)) % 40);
        d.unused    = '0;
        @(posedge clk);
        queue_sel <= queue_idx_w'($unsigned($random(seed)));
        desc_in   <= d;
        dma_done  <= 1'b1;
        @(posedge clk);
        dma_done <= 1'b0;
        @(posedge clk);
    endtask

    // tx_allowed keeps toggling until data_req shows the new frame
    task automatic wait_grant(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 400 && !ok; n++) begin
            @(posedge clk);
            if (data_req) begin
                ok = 1'b1;
                tx_allowed <= '0;
            end else begin
                tx_allowed <= num_queues'($unsigned($random(seed)));
            end
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: no frame started within 400 cycles");
        end
    endtask

    task automatic wait_load_done(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 1000 && !ok; n++) begin
            @(posedge clk);
            ok = !data_req;
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: data_req still high after 1000 cycles");
        end
    endtask

    // PHY side readback, the checker compares the words it has seen
    task automatic read_buffer();
        for (int a = 0; a < 40; a++) begin
            bram_addr <= buf_addr_w'(a);
            rd_check  <= 1'b1;
            @(posedge clk);
        end
        rd_check <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic run_frame(output bit ok);
        int nw;
        nw = 1 + $unsigned($random(seed)) % 2;
        for (int i = 0; i < nw; i++)
            write_desc();
        repeat (4) @(posedge clk);
        // baseband busy, no grant whatever the mask
        bb_busy         <= 1'b1;
        auto_start      <= ($random(seed) % 2) != 0;
        start_threshold <= buf_addr_w'($unsigned($random(seed)) % 48);
        repeat (8) begin
            @(posedge clk);
            tx_allowed <= num_queues'($unsigned($random(seed)));
        end
        @(posedge clk);
        bb_busy <= 1'b0;
        wait_grant(ok);
        if (ok)
            wait_load_done(ok);
        if (ok) begin
            repeat (3) @(posedge clk);
            tx_end <= 1'b1;
            @(posedge clk);
            tx_end  <= 1'b0;
            tx_done <= 1'b1;
            @(posedge clk);
            tx_done <= 1'b0;
            read_buffer();
        end
    endtask

    task automatic finish_run();
        report = 1'b1;
        #1;
        if (chk_errs + assert_errs + timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        rstn            = 1'b0;
        dma_done        = 1'b0;
        queue_sel       = '0;
        desc_in         = '0;
        tx_allowed      = '0;
        bb_busy         = 1'b0;
        tx_end          = 1'b0;
        tx_done         = 1'b0;
        auto_start      = 1'b0;
        start_threshold = '0;
        bram_addr       = '0;
        rd_check        = 1'b0;
        report          = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        ok = 1'b1;
        for (int f = 0; f < n_frames && ok; f++)
            run_frame(ok);
        finish_run();
    end

endmodule

// ==== tx_bit_intf.f ====
tx_bit_pkg.sv
tx_desc_fifo.sv
tx_desc_intake.sv
tx_queue_arbiter.sv
tx_frame_loader.sv
tx_pkt_buffer.sv
tx_bit_intf.sv
tx_bit_intf_assertions.sv
tx_bit_intf_checker.sv
tb_tx_bit_intf.sv

// ==== tx_bit_intf.sv ====
// top level of the tx bit interface, connects intake, arbiter, loader and packet buffer
`timescale 1ns/10ps

module tx_bit_intf (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               dma_done,
    input  logic [tx_bit_pkg::queue_idx_w-1:0] queue_sel,
    input  tx_bit_pkg::tx_desc_t               desc_in,
    input  logic [tx_bit_pkg::num_queues-1:0]  tx_allowed,
    input  logic                               bb_busy,
    input  logic                               tx_end,
    input  logic                               tx_done,
    input  logic                               auto_start,
    input  logic [tx_bit_pkg::buf_addr_w-1:0]  start_threshold,
    input  logic [tx_bit_pkg::data_w-1:0]      data_in,
    input  logic                               data_valid,
    output logic                               data_req,
    input  logic [tx_bit_pkg::buf_addr_w-1:0]  bram_addr,
    output logic [tx_bit_pkg::data_w-1:0]      bram_rd_data,
    output logic                               start,
    output logic [tx_bit_pkg::queue_idx_w-1:0] tx_queue_idx,
    output logic                               need_ack,
    output logic [3:0]                         retry_limit,
    output logic [9:0]                         seq_num,
    output logic [1:0]                         prio
);
    import tx_bit_pkg::*;

    logic [num_queues-1:0]             fifo_empty;
    tx_desc_t [num_queues-1:0]         head;
    logic [num_queues-1:0]             pop;
    logic                              load_go;
    logic [12:0]                       cur_len;
    logic                              buf_wr_en;
    logic [buf_addr_w-1:0]             buf_wr_addr;
    logic [data_w-1:0]                 buf_wr_data;

    tx_desc_intake i_intake (
        .clk        (clk),
        .rstn       (rstn),
        .dma_done   (dma_done),
        .queue_sel  (queue_sel),
        .desc_in    (desc_in),
        .pop        (pop),
        .fifo_empty (fifo_empty),
        .head       (head)
    );

    tx_queue_arbiter i_arbiter (
        .clk          (clk),
        .rstn         (rstn),
        .tx_allowed   (tx_allowed),
        .bb_busy      (bb_busy),
        .tx_end       (tx_end),
        .tx_done      (tx_done),
        .fifo_empty   (fifo_empty),
        .head         (head),
        .pop          (pop),
        .load_go      (load_go),
        .cur_len      (cur_len),
        .tx_queue_idx (tx_queue_idx),
        .need_ack     (need_ack),
        .retry_limit  (retry_limit),
        .seq_num      (seq_num),
        .prio         (prio)
    );

    // loader is the only writer of the buffer
    tx_frame_loader i_loader (
        .clk             (clk),
        .rstn            (rstn),
        .load_go         (load_go),
        .tx_end          (tx_end),
        .auto_start      (auto_start),
        .cur_len         (cur_len),
        .start_threshold (start_threshold),
        .data_in         (data_in),
        .data_valid      (data_valid),
        .data_req        (data_req),
        .wr_en           (buf_wr_en),
        .wr_addr         (buf_wr_addr),
        .wr_data         (buf_wr_data),
        .start           (start)
    );

    // phy side read port
    tx_pkt_buffer i_buffer (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .rd_addr (bram_addr),
        .wr_data (buf_wr_data),
        .rd_data (bram_rd_data)
    );

endmodule

// ==== tx_bit_intf_assertions.sv ====
// protocol assertions on the queue arbiter, bound into it from the testbench top
`timescale 1ns/10ps

module tx_bit_intf_assertions (
    input logic                              clk,
    input logic                              rstn,
    input logic [tx_bit_pkg::num_queues-1:0] pop,
    input logic                              load_go,
    input logic                              bb_busy,
    input tx_bit_pkg::frame_state_t          state
);
    import tx_bit_pkg::*;

    // failed assertions so far, read by the testbench top
    int fail_cnt = 0;

    // at most one queue popped per cycle
    a_pop_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(pop))
        else begin
            $error("pop is not one-hot or zero: %h", pop);
            fail_cnt++;
        end

    // load_go is a single-cycle strobe
    a_load_go_strobe: assert property (@(posedge clk) disable iff (!rstn) load_go |=> !load_go)
        else begin
            $error("load_go stayed high for more than one cycle");
            fail_cnt++;
        end

    // busy baseband blocks any grant from idle
    a_no_pop_busy: assert property (@(posedge clk) disable iff (!rstn)
        (state == idle && bb_busy) |-> (pop == '0))
        else begin
            $error("queue popped in idle while bb_busy was high");
            fail_cnt++;
        end

endmodule

// ==== tx_bit_intf_checker.sv ====
// reference model of the tx bit interface, compares the DUT each cycle and counts errors
`timescale 1ns/10ps

module tx_bit_intf_checker (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               dma_done,
    input  logic [tx_bit_pkg::queue_idx_w-1:0] queue_sel,
    input  tx_bit_pkg::tx_desc_t               desc_in,
    input  logic [tx_bit_pkg::num_queues-1:0]  tx_allowed,
    input  logic                               bb_busy,
    input  logic                               tx_end,
    input  logic                               tx_done,
    input  logic                               auto_start,
    input  logic [tx_bit_pkg::buf_addr_w-1:0]  start_threshold,
    input  logic [tx_bit_pkg::data_w-1:0]      data_in,
    input  logic                               data_valid,
    input  logic                               data_req,
    input  logic [tx_bit_pkg::buf_addr_w-1:0]  bram_addr,
    input  logic                               rd_check,
    input  logic [tx_bit_pkg::data_w-1:0]      bram_rd_data,
    input  logic                               start,
    input  logic [tx_bit_pkg::queue_idx_w-1:0] tx_queue_idx,
    input  logic                               need_ack,
    input  logic [3:0]                         retry_limit,
    input  logic [9:0]                         seq_num,
    input  logic [1:0]                         prio,
    input  logic                               report,
    input  int                                 assert_errs,
    input  int                                 timeouts,
    output int                                 errs
);
    import tx_bit_pkg::*;

    // expected content of each descriptor fifo
    tx_desc_t              model_q [num_queues][$];
    tx_desc_t              cur;
    logic [data_w-1:0]     words [64];
    // grant inputs seen over the last four cycles
    logic [num_queues-1:0] allow_h [4];
    logic [3:0]            busy_h;
    logic [6:0]            start_sr;
    logic                  done_prev;
    logic                  req_prev;
    logic                  done_pend;
    logic                  rd_pend;
    logic [buf_addr_w-1:0] rd_addr_d;
    int                    n_taken;
    int                    exp_len;
    int                    value_errs = 0;
    int                    proto_errs = 0;

    assign errs = value_errs + proto_errs;

    task automatic value_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] got);
        value_errs++;
        $display("[FAIL] %s: expected %h, got %h", name, exp, got);
    endtask

    task automatic protocol_error(input string what);
        proto_errs++;
        $display("error: %s at %0t", what, $time);
    endtask

    always @(posedge clk) begin
        int   exp_q;
        logic hit;
        if (!rstn) begin
            for (int q = 0; q < num_queues; q++)
                model_q[q].delete();
            for (int k = 0; k < 4; k++)
                allow_h[k] = '0;
            busy_h    = '0;
            start_sr  = '0;
            done_prev = 1'b0;
            req_prev  = 1'b0;
            done_pend = 1'b0;
            rd_pend   = 1'b0;
            n_taken   = 0;
            exp_len   = 0;
        end else begin
            hit = 1'b0;
            // dma done falling edge queues a descriptor
            if (done_prev && !dma_done)
                model_q[queue_sel].push_back(desc_in);
            // new frame, grant cycle lies four samples back
            if (data_req && !req_prev) begin
                exp_q = -1;
                for (int q = 0; q < num_queues && exp_q < 0; q++)
                    if (allow_h[3][q] && model_q[q].size() != 0)
                        exp_q = q;
                if (busy_h[3])
                    protocol_error("frame began while bb_busy was high");
                if (exp_q < 0) begin
                    protocol_error("frame began with no allowed non-empty queue");
                    exp_len = 0;
                end else begin
                    cur     = model_q[exp_q].pop_front();
                    exp_len = int'(cur.len_words);
                    if (tx_queue_idx != queue_idx_w'(exp_q))
                        value_mismatch("tx_queue_idx", exp_q, tx_queue_idx);
                    if (need_ack != cur.need_ack)
                        value_mismatch("need_ack", cur.need_ack, need_ack);
                    if (retry_limit != cur.retry_limit)
                        value_mismatch("retry_limit", cur.retry_limit, retry_limit);
                end
                n_taken = 0;
            end
            // stream handshake
            if (data_req && data_valid) begin
                if (n_taken >= exp_len) begin
                    protocol_error("word taken after the last word of the frame");
                end else begin
                    words[n_taken] = data_in;
                    hit = auto_start && (n_taken == int'(start_threshold));
                end
                n_taken++;
            end
            if (tx_end && n_taken != exp_len)
                value_mismatch("words taken", exp_len, n_taken);
            // seq_num and prio land one cycle after tx_done
            if (done_pend) begin
                if (seq_num != cur.seq_num)
                    value_mismatch("seq_num", cur.seq_num, seq_num);
                if (prio != cur.prio)
                    value_mismatch("prio", cur.prio, prio);
            end
            done_pend = tx_done;
            // buffer read data one cycle after the address
            if (rd_pend && int'(rd_addr_d) < n_taken && bram_rd_data != words[rd_addr_d])
                value_mismatch("bram_rd_data", words[rd_addr_d], bram_rd_data);
            rd_pend   = rd_check;
            rd_addr_d = bram_addr;
            // start high two to seven cycles after the threshold word is taken
            if (start != (|start_sr[6:1]))
                value_mismatch("start", |start_sr[6:1], start);
            start_sr = {start_sr[5:0], hit};
            for (int k = 3; k > 0; k--)
                allow_h[k] = allow_h[k-1];
            allow_h[0] = tx_allowed;
            busy_h     = {busy_h[2:0], bb_busy};
            done_prev  = dma_done;
            req_prev   = data_req;
        end
    end

    always @(posedge report) begin
        $display("errors: value %0d, protocol %0d, assertion %0d, timeout %0d",
                 value_errs, proto_errs, assert_errs, timeouts);
    end

endmodule

// ==== tx_bit_pkg.sv ====
// shared sizes, descriptor layout and frame FSM states for the tx bit interface RTL
package tx_bit_pkg;

    // queue count and index width
    localparam int num_queues      = 4;
    localparam int queue_idx_w     = 2;

    // stream word and packet buffer sizes
    localparam int data_w          = 64;
    localparam int buf_addr_w      = 10;

    // descriptor fifo depth, power of two so pointers wrap freely
    localparam int desc_fifo_depth = 64;
    localparam int fifo_ptr_w      = $clog2(desc_fifo_depth);

    // start pulse width in clk cycles
    localparam int start_pulse_len = 6;

    // dma descriptor as written by software, msb first
    typedef struct packed {
        logic [1:0]  prio;
        logic [9:0]  seq_num;
        logic [1:0]  unused;
        logic [3:0]  retry_limit;
        logic        need_ack;
        logic [12:0] len_words;
    } tx_desc_t;

    // per-frame control flow
    typedef enum logic [1:0] {
        idle  = 2'd0,
        fetch = 2'd1,
        judge = 2'd2,
        load  = 2'd3
    } frame_state_t;

endpackage

// ==== tx_desc_fifo.sv ====
// one synchronous descriptor fifo, instantiated once per transmit queue by the intake
`timescale 1ns/10ps

module tx_desc_fifo (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 wr_en,
    input  logic                 rd_en,
    input  tx_bit_pkg::tx_desc_t wr_data,
    output tx_bit_pkg::tx_desc_t rd_data,
    output logic                 empty,
    output logic                 full
);
    import tx_bit_pkg::*;

    tx_desc_t              mem [desc_fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    // writes to a full fifo and reads from an empty one are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;
    assign empty = (count == '0);
    assign full  = (count == (fifo_ptr_w + 1)'(desc_fifo_depth));

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr];
    end

    // pointers wrap at depth
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== tx_desc_intake.sv ====
// turns the end of each dma transfer into a descriptor write on its queue fifo
`timescale 1ns/10ps

module tx_desc_intake (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic                                             dma_done,
    input  logic [tx_bit_pkg::queue_idx_w-1:0]               queue_sel,
    input  tx_bit_pkg::tx_desc_t                             desc_in,
    input  logic [tx_bit_pkg::num_queues-1:0]                pop,
    output logic [tx_bit_pkg::num_queues-1:0]                fifo_empty,
    output tx_bit_pkg::tx_desc_t [tx_bit_pkg::num_queues-1:0] head
);
    import tx_bit_pkg::*;

    logic                  dma_done_d;
    logic                  done_fall;
    logic [num_queues-1:0] wr_en;
    logic [num_queues-1:0] fifo_full;
    tx_desc_t              wr_desc;

    // dma finished on the high to low transition
    assign done_fall = dma_done_d && !dma_done;

    // one-hot write enable, skip a queue that is already full
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dma_done_d <= 1'b0;
            wr_en      <= '0;
        end else begin
            dma_done_d <= dma_done;
            wr_en      <= '0;
            if (done_fall && !fifo_full[queue_sel])
                wr_en[queue_sel] <= 1'b1;
        end
    end

    // hold descriptor for the delayed write
    always_ff @(posedge clk) begin
        if (done_fall)
            wr_desc <= desc_in;
    end

    for (genvar q = 0; q < num_queues; q++) begin : g_fifo
        tx_desc_fifo i_fifo (
            .clk     (clk),
            .rstn    (rstn),
            .wr_en   (wr_en[q]),
            .rd_en   (pop[q]),
            .wr_data (wr_desc),
            .rd_data (head[q]),
            .empty   (fifo_empty[q]),
            .full    (fifo_full[q])
        );
    end

endmodule

// ==== tx_frame_loader.sv ====
// pulls a frame from the dma stream into the packet buffer and shapes the phy start pulse
`timescale 1ns/10ps

module tx_frame_loader (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              load_go,
    input  logic                              tx_end,
    input  logic                              auto_start,
    input  logic [12:0]                       cur_len,
    input  logic [tx_bit_pkg::buf_addr_w-1:0] start_threshold,
    input  logic [tx_bit_pkg::data_w-1:0]     data_in,
    input  logic                              data_valid,
    output logic                              data_req,
    output logic                              wr_en,
    output logic [tx_bit_pkg::buf_addr_w-1:0] wr_addr,
    output logic [tx_bit_pkg::data_w-1:0]     wr_data,
    output logic                              start
);
    import tx_bit_pkg::*;

    logic [12:0]                word_cnt;
    logic                       take;
    logic                       thr_hit;
    logic [start_pulse_len-1:0] start_sr;

    // a word moves when both sides agree
    assign take = data_req && data_valid;

    // threshold write arms the pulse, only in auto start mode
    assign thr_hit = wr_en && (wr_addr == start_threshold) && auto_start;

    // each stage adds one cycle of pulse width
    assign start = |start_sr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_req <= 1'b0;
            word_cnt <= '0;
            wr_en    <= 1'b0;
            start_sr <= '0;
        end else begin
            wr_en    <= take;
            start_sr <= {start_sr[start_pulse_len-2:0], thr_hit};
            if (tx_end) begin
                // phy finished, abandon any remaining request
                data_req <= 1'b0;
            end else if (load_go) begin
                data_req <= 1'b1;
                word_cnt <= '0;
            end else if (take) begin
                word_cnt <= word_cnt + 1'b1;
                // last word taken, stop asking
                if (word_cnt == cur_len - 13'd1)
                    data_req <= 1'b0;
            end
        end
    end

    // buffer write one cycle after the word is taken
    always_ff @(posedge clk) begin
        if (take) begin
            wr_addr <= word_cnt[buf_addr_w-1:0];
            wr_data <= data_in;
        end
    end

endmodule

// ==== tx_pkt_buffer.sv ====
// packet memory, loader writes on one port and the phy reads on the other
`timescale 1ns/10ps

module tx_pkt_buffer (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [tx_bit_pkg::buf_addr_w-1:0] wr_addr,
    input  logic [tx_bit_pkg::buf_addr_w-1:0] rd_addr,
    input  logic [tx_bit_pkg::data_w-1:0]     wr_data,
    output logic [tx_bit_pkg::data_w-1:0]     rd_data
);
    import tx_bit_pkg::*;

    logic [data_w-1:0] mem [2**buf_addr_w];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // read port, one cycle latency
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== tx_queue_arbiter.sv ====
// strict-priority queue grant and frame FSM driving the loader and the descriptor outputs
`timescale 1ns/10ps

module tx_queue_arbiter (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic [tx_bit_pkg::num_queues-1:0]                tx_allowed,
    input  logic                                             bb_busy,
    input  logic                                             tx_end,
    input  logic                                             tx_done,
    input  logic [tx_bit_pkg::num_queues-1:0]                fifo_empty,
    input  tx_bit_pkg::tx_desc_t [tx_bit_pkg::num_queues-1:0] head,
    output logic [tx_bit_pkg::num_queues-1:0]                pop,
    output logic                                             load_go,
    output logic [12:0]                                      cur_len,
    output logic [tx_bit_pkg::queue_idx_w-1:0]               tx_queue_idx,
    output logic                                             need_ack,
    output logic [3:0]                                       retry_limit,
    output logic [9:0]                                       seq_num,
    output logic [1:0]                                       prio
);
    import tx_bit_pkg::*;

    frame_state_t           state;
    tx_desc_t               cur_desc;
    logic [queue_idx_w-1:0] sel_idx;
    logic [queue_idx_w-1:0] grant_idx;
    logic                   grant_any;
    logic                   start_ok;

    // lowest index wins, so scan from the top down
    always_comb begin
        grant_any = 1'b0;
        grant_idx = '0;
        for (int q = num_queues - 1; q >= 0; q--) begin
            if (tx_allowed[q] && !fifo_empty[q]) begin
                grant_any = 1'b1;
                grant_idx = queue_idx_w'(q);
            end
        end
    end

    // new frame only from idle with baseband quiet
    assign start_ok = (state == idle) && grant_any && !bb_busy;

    // pop in the grant cycle, fifo head is then valid in fetch
    always_comb begin
        pop = '0;
        if (start_ok)
            pop[grant_idx] = 1'b1;
    end

    assign cur_len     = cur_desc.len_words;
    assign need_ack    = cur_desc.need_ack;
    assign retry_limit = cur_desc.retry_limit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= idle;
            sel_idx      <= '0;
            cur_desc     <= '0;
            tx_queue_idx <= '0;
            load_go      <= 1'b0;
            seq_num      <= '0;
            prio         <= '0;
        end else begin
            load_go <= 1'b0;
            case (state)
                idle: begin
                    if (start_ok) begin
                        sel_idx <= grant_idx;
                        state   <= fetch;
                    end
                end
                fetch: begin
                    // descriptor held until the next fetch
                    cur_desc     <= head[sel_idx];
                    tx_queue_idx <= sel_idx;
                    state        <= judge;
                end
                judge: begin
                    load_go <= 1'b1;
                    state   <= load;
                end
                load: begin
                    if (tx_end)
                        state <= idle;
                end
                default: state <= idle;
            endcase
            // report fields of the frame just completed
            if (tx_done) begin
                seq_num <= cur_desc.seq_num;
                prio    <= cur_desc.prio;
            end
        end
    end

endmodule
